//--- src.f
verilog/ps2_pkg.sv
verilog/kbd_pkg.sv
verilog/ps2_line_filter.sv
verilog/ps2_frame_receiver.sv
verilog/scan_code_assembler.sv
verilog/scan_code_queue.sv
verilog/kbd_controller.sv
tests/tb_kbd_controller.sv

//--- tests/tb_kbd_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard model runs at 60 clk cycles per PS/2 bit.
// Assumes timeout_cycles 400 and a 16-entry queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tb_kbd_controller;

  import kbd_pkg::*;

  typedef logic [7:0]  byte_q_t[$];
  typedef int          kind_q_t[$];
  typedef logic [15:0] code_q_t[$];

  // Frame variants of the keyboard model
  localparam int kind_good    = 0;
  localparam int kind_bad_par = 1;
  localparam int kind_short   = 2;
  localparam int kind_glitch  = 3;

  localparam int total_frames    = 52;
  localparam int watchdog_cycles = total_frames * 11 * 60 + 30000;

  logic        clk = 1'b0;
  logic        rst;
  logic        ps2_clk;
  logic        ps2_data;
  logic        accept;
  scan_code_t  scan_code;
  logic        irq;

  code_q_t     exp_q;
  logic        reader_en;
  logic        reading;
  string       cur_test;
  int          err_count;
  int          tests_passed;
  int          tests_failed;
  logic [31:0] lcg_state;

  kbd_controller #(
    .filter_len      (8),
    .timeout_cycles  (400),
    .queue_addr_bits (4)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .accept    (accept),
    .scan_code (scan_code),
    .irq       (irq)
  );

  always #50 clk = ~clk;

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // Random code byte that is never taken for a prefix
  function automatic logic [7:0] rand_code();
    logic [7:0] b;
    b = next_rand();
    while (b == 8'hE0 || b == 8'hF0) begin
      b = next_rand();
    end
    return b;
  endfunction

  // Bad and cut frames vanish, the last prefix wins and cap limits the queue
  function automatic code_q_t expected_codes(input byte_q_t bytes, input kind_q_t kinds,
                                             input int cap);
    code_q_t    res;
    logic [7:0] pfx;
    pfx = 8'h00;
    foreach (bytes[i]) begin
      if (kinds[i] == kind_bad_par || kinds[i] == kind_short) begin
        continue;
      end
      if (bytes[i] == 8'hE0 || bytes[i] == 8'hF0) begin
        pfx = bytes[i];
      end else begin
        if (res.size() < cap) begin
          res.push_back({pfx, bytes[i]});
        end
        pfx = 8'h00;
      end
    end
    return res;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Drives one frame of start, 8 data bits LSB first, odd parity and stop
  task automatic send_frame(input logic [7:0] data, input int kind);
    logic [10:0] bits;
    int          n_bits;
    bits = {1'b1, ~^data, data, 1'b0};
    if (kind == kind_bad_par) begin
      bits[9] = ^data;
    end
    n_bits = (kind == kind_short) ? 4 : 11;
    for (int i = 0; i < n_bits; i++) begin
      if (kind == kind_glitch) begin
        // Short low pulse in the high half
        wait_cycles(3);
        ps2_clk = 1'b0;
        wait_cycles(5);
        ps2_clk = 1'b1;
        wait_cycles(7);
      end else begin
        wait_cycles(15);
      end
      ps2_data = bits[i];
      wait_cycles(15);
      ps2_clk = 1'b0;
      if (kind == kind_glitch) begin
        wait_cycles(18);
        ps2_clk = 1'b1;
        wait_cycles(5);
        ps2_clk = 1'b0;
        wait_cycles(7);
      end else begin
        wait_cycles(30);
      end
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    // A cut frame is followed by a pause past the receiver timeout
    wait_cycles(kind == kind_short ? 600 : 100);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || reading) && n < 3000) begin
      @(negedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: %0d expected codes never arrived", cur_test, exp_q.size());
      err_count++;
    end
  endtask

  task automatic run_test(input string name, input byte_q_t bytes, input kind_q_t kinds,
                          input bit hold);
    int errs_before;
    errs_before = err_count;
    cur_test    = name;
    exp_q       = expected_codes(bytes, kinds, hold ? 15 : 65536);
    reader_en   = !hold;
    foreach (bytes[i]) begin
      send_frame(bytes[i], kinds[i]);
    end
    if (hold) begin
      wait_cycles(40);
      assert (irq === 1'b1) else begin
        $display("%s: irq is low although codes are waiting in the queue", name);
        err_count++;
      end
      reader_en = 1'b1;
    end
    wait_drained();
    wait_cycles(50);
    assert (irq === 1'b0) else begin
      $display("%s: irq still high after the last expected code was read", name);
      err_count++;
    end
    reader_en = 1'b0;
    if (err_count == errs_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail", name);
    end
  endtask

  // Compares the head of the queue on each irq and then accepts it
  always begin
    wait (reader_en && irq === 1'b1);
    reading = 1'b1;
    @(negedge clk);
    assert (exp_q.size() > 0) else begin
      $display("%s: unexpected code %h from the DUT", cur_test, scan_code);
      err_count++;
    end
    if (exp_q.size() > 0) begin
      assert (scan_code == exp_q[0]) else begin
        $display("error %s: expected %h, actual %h", cur_test, exp_q[0], scan_code);
        err_count++;
      end
      void'(exp_q.pop_front());
    end
    accept = 1'b1;
    @(negedge clk);
    accept = 1'b0;
    assert (irq === 1'b0) else begin
      $display("%s: irq did not drop after accept", cur_test);
      err_count++;
    end
    reading = 1'b0;
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: simulation did not finish within %0d clock cycles", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    byte_q_t bytes;
    kind_q_t kinds;
    rst          = 1'b1;
    ps2_clk      = 1'b1;
    ps2_data     = 1'b1;
    accept       = 1'b0;
    reader_en    = 1'b0;
    reading      = 1'b0;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    lcg_state    = 32'd91;
    cur_test     = "reset";
    repeat (16) @(negedge clk);
    rst = 1'b0;
    wait_cycles(20);

    for (int i = 0; i < 20; i++) begin
      bytes.push_back(rand_code());
      kinds.push_back(kind_good);
    end
    run_test("random_single", bytes, kinds, 1'b0);

    bytes = '{8'hE0, rand_code(), 8'hF0, rand_code(), 8'hE0, 8'hF0, rand_code()};
    kinds = '{kind_good, kind_good, kind_good, kind_good, kind_good, kind_good, kind_good};
    run_test("prefixes", bytes, kinds, 1'b0);

    bytes = '{rand_code(), rand_code()};
    kinds = '{kind_bad_par, kind_good};
    run_test("bad_parity", bytes, kinds, 1'b0);

    bytes = '{rand_code(), rand_code(), rand_code(), rand_code()};
    kinds = '{kind_glitch, kind_glitch, kind_glitch, kind_glitch};
    run_test("clock_glitches", bytes, kinds, 1'b0);

    bytes = '{rand_code(), rand_code()};
    kinds = '{kind_short, kind_good};
    run_test("frame_timeout", bytes, kinds, 1'b0);

    bytes.delete();
    kinds.delete();
    for (int i = 0; i < 17; i++) begin
      bytes.push_back(rand_code());
      kinds.push_back(kind_good);
    end
    run_test("queue_full", bytes, kinds, 1'b1);

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/kbd_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PS/2 keyboard receiver for the receive direction
// only. accept must be a single-cycle strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module kbd_controller #(
  parameter int filter_len      = 8,
  parameter int timeout_cycles  = 4096,
  parameter int queue_addr_bits = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  input  logic                accept,
  output kbd_pkg::scan_code_t scan_code,
  output logic                irq
);

  import ps2_pkg::*;
  import kbd_pkg::*;

  ps2_lines_t lines_f;
  logic       clk_fall;
  rx_byte_t   rx_byte;
  scan_code_t code;
  logic       code_strobe;

  ps2_line_filter #(
    .filter_len (filter_len)
  ) i_filter (
    .clk      (clk),
    .rst      (rst),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .lines_f  (lines_f),
    .clk_fall (clk_fall)
  );

  ps2_frame_receiver #(
    .timeout_cycles (timeout_cycles)
  ) i_receiver (
    .clk      (clk),
    .rst      (rst),
    .lines_f  (lines_f),
    .clk_fall (clk_fall),
    .rx_byte  (rx_byte)
  );

  scan_code_assembler i_assembler (
    .clk         (clk),
    .rst         (rst),
    .rx_byte     (rx_byte),
    .code        (code),
    .code_strobe (code_strobe)
  );

  scan_code_queue #(
    .queue_addr_bits (queue_addr_bits)
  ) i_queue (
    .clk         (clk),
    .rst         (rst),
    .code        (code),
    .code_strobe (code_strobe),
    .accept      (accept),
    .scan_code   (scan_code),
    .irq         (irq)
  );

endmodule

`default_nettype wire

//--- verilog/kbd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard code level types for scan code set 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package kbd_pkg;

  // Prefix bytes that precede a code byte
  // pfx_none marks a plain make code
  typedef enum logic [7:0] {
    pfx_none  = 8'h00,
    pfx_ext   = 8'hE0,
    pfx_break = 8'hF0
  } prefix_e;

  // Complete scan code as seen by the host
  // Prefix in the upper byte, code byte in the lower byte
  typedef struct packed {
    prefix_e    prefix;
    logic [7:0] code;
  } scan_code_t;

endpackage

`default_nettype wire

//--- verilog/ps2_frame_receiver.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frames with bad parity or stop bit are dropped
// silently. timeout_cycles must be >= 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module ps2_frame_receiver #(
  parameter int timeout_cycles = 4096
) (
  input  logic                clk,
  input  logic                rst,
  input  ps2_pkg::ps2_lines_t lines_f,
  input  logic                clk_fall,
  output ps2_pkg::rx_byte_t   rx_byte
);

  import ps2_pkg::*;

  localparam int cnt_w = $clog2(timeout_cycles + 1);

  rx_state_e        state;
  logic [2:0]       bit_cnt;
  logic [7:0]       shift_q;
  logic             par_acc;
  logic             strobe_q;
  logic [cnt_w-1:0] idle_cnt;
  logic             din;

  assign din = lines_f.data_line;

  // Control path, advanced on each falling edge of the keyboard clock
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      bit_cnt  <= '0;
      strobe_q <= 1'b0;
      idle_cnt <= '0;
    end else begin
      strobe_q <= 1'b0;
      if (clk_fall) begin
        idle_cnt <= '0;
        unique case (state)
          st_idle: begin
            // A start bit of 1 is not a frame
            if (!din) begin
              state   <= st_data;
              bit_cnt <= '0;
            end
          end
          st_data: begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= st_parity;
            end
          end
          st_parity: begin
            state <= st_stop;
          end
          st_stop: begin
            strobe_q <= din & par_acc;
            state    <= st_idle;
          end
        endcase
      end else if (state != st_idle) begin
        // Keyboard went quiet in mid frame
        if (idle_cnt == cnt_w'(timeout_cycles - 1)) begin
          state    <= st_idle;
          bit_cnt  <= '0;
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

  // Data shifts in LSB first, parity accumulates over data and parity bit
  always_ff @(posedge clk) begin
    if (clk_fall) begin
      if (state == st_idle) begin
        par_acc <= 1'b0;
      end else if (state == st_data) begin
        shift_q <= {din, shift_q[7:1]};
        par_acc <= par_acc ^ din;
      end else if (state == st_parity) begin
        par_acc <= par_acc ^ din;
      end
    end
  end

  assign rx_byte = '{data: shift_q, strobe: strobe_q};

  a_cnt_range: assert property (@(posedge clk) disable iff (rst)
    state != st_data |-> bit_cnt == 3'd0);

  a_strobe_src: assert property (@(posedge clk) disable iff (rst)
    strobe_q |-> $past(state == st_stop && clk_fall));

endmodule

`default_nettype wire

//--- verilog/ps2_line_filter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raw lines are asynchronous. filter_len must be >= 2
// and shorter than half a PS/2 bit in clk cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module ps2_line_filter #(
  parameter int filter_len = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  output ps2_pkg::ps2_lines_t lines_f,
  output logic                clk_fall
);

  // Index 0 is the clock line, index 1 the data line
  logic [1:0]            raw;
  logic [1:0]            sync_a;
  logic [1:0]            sync_b;
  logic [filter_len-1:0] hist [2];
  logic [1:0]            filt_q;
  logic                  clk_prev;

  assign raw = {ps2_data, ps2_clk};

  always_ff @(posedge clk) begin
    if (rst) begin
      // Idle bus is high on both lines
      sync_a   <= '1;
      sync_b   <= '1;
      hist[0]  <= '1;
      hist[1]  <= '1;
      filt_q   <= '1;
      clk_prev <= 1'b1;
    end else begin
      sync_a <= raw;
      sync_b <= sync_a;
      for (int i = 0; i < 2; i++) begin
        hist[i] <= {hist[i][filter_len-2:0], sync_b[i]};
        // Only a unanimous history moves the output
        if (&hist[i]) begin
          filt_q[i] <= 1'b1;
        end else if (~|hist[i]) begin
          filt_q[i] <= 1'b0;
        end
      end
      clk_prev <= filt_q[0];
    end
  end

  assign lines_f  = '{clk_line: filt_q[0], data_line: filt_q[1]};
  assign clk_fall = clk_prev & ~filt_q[0];

  for (genvar g = 0; g < 2; g++) begin : g_chk
    a_unanimous: assert property (@(posedge clk) disable iff (rst)
      $changed(filt_q[g]) |-> $past(hist[g]) == {filter_len{filt_q[g]}});
  end

  a_fall_low: assert property (@(posedge clk) disable iff (rst)
    clk_fall |-> !lines_f.clk_line && $past(lines_f.clk_line));

endmodule

`default_nettype wire

//--- verilog/ps2_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PS/2 line level types. Device-to-host only, so the
// lines are never driven by this side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package ps2_pkg;

  // Filtered copies of the two open-collector lines, idle high
  typedef struct packed {
    logic clk_line;
    logic data_line;
  } ps2_lines_t;

  // Frame receiver states
  // st_idle waits for a start bit of 0
  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_parity,
    st_stop
  } rx_state_e;

  // One received byte with its single-cycle valid pulse
  typedef struct packed {
    logic [7:0] data;
    logic       strobe;
  } rx_byte_t;

endpackage

`default_nettype wire

//--- verilog/scan_code_assembler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Only the last prefix before a code byte is kept
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module scan_code_assembler (
  input  logic                clk,
  input  logic                rst,
  input  ps2_pkg::rx_byte_t   rx_byte,
  output kbd_pkg::scan_code_t code,
  output logic                code_strobe
);

  import kbd_pkg::*;

  prefix_e    prefix_q;
  prefix_e    byte_kind;
  logic       is_prefix;
  scan_code_t code_q;
  logic       strobe_q;

  // Incoming byte viewed as a possible prefix
  assign byte_kind = prefix_e'(rx_byte.data);
  assign is_prefix = (byte_kind == pfx_ext) || (byte_kind == pfx_break);

  always_ff @(posedge clk) begin
    if (rst) begin
      prefix_q <= pfx_none;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      if (rx_byte.strobe) begin
        if (is_prefix) begin
          // A newer prefix replaces a pending one
          prefix_q <= byte_kind;
        end else begin
          strobe_q <= 1'b1;
          prefix_q <= pfx_none;
        end
      end
    end
  end

  // Code register holds the last complete scan code
  always_ff @(posedge clk) begin
    if (rx_byte.strobe && !is_prefix) begin
      code_q <= '{prefix: prefix_q, code: rx_byte.data};
    end
  end

  assign code        = code_q;
  assign code_strobe = strobe_q;

  a_no_prefix_code: assert property (@(posedge clk) disable iff (rst)
    code_strobe |-> $past(rx_byte.strobe) && !(code.code inside {8'hE0, 8'hF0}));

endmodule

`default_nettype wire

//--- verilog/scan_code_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Holds depth-1 codes. Pushes into a full queue are
// lost; accept on an empty queue is ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module scan_code_queue #(
  parameter int queue_addr_bits = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  kbd_pkg::scan_code_t code,
  input  logic                code_strobe,
  input  logic                accept,
  output kbd_pkg::scan_code_t scan_code,
  output logic                irq
);

  import kbd_pkg::*;

  localparam int depth = 1 << queue_addr_bits;

  scan_code_t                 mem [depth];
  logic [queue_addr_bits-1:0] put;
  logic [queue_addr_bits-1:0] get;
  logic                       empty;
  logic                       full;
  logic                       push;
  logic                       pop;
  logic                       irq_q;

  assign empty = (put == get);
  // One slot stays free so that full and empty differ
  assign full  = (put == queue_addr_bits'(get - 1'b1));
  assign push  = code_strobe & ~full;
  assign pop   = accept & ~empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[put] <= code;
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge clk) begin
    if (rst) begin
      put   <= '0;
      get   <= '0;
      irq_q <= 1'b0;
    end else begin
      if (push) begin
        put <= put + 1'b1;
      end
      if (pop) begin
        get <= get + 1'b1;
      end
      // Drops for a cycle after each accept, then rises again if data remains
      irq_q <= !empty && !accept;
    end
  end

  // Head of queue is always visible
  assign scan_code = mem[get];
  assign irq       = irq_q;

  a_get_move: assert property (@(posedge clk) disable iff (rst)
    get != $past(get) |-> $past(accept && !empty));

  a_put_move: assert property (@(posedge clk) disable iff (rst)
    put != $past(put) |-> $past(code_strobe && !full));

  a_irq_data: assert property (@(posedge clk) disable iff (rst)
    irq |-> $past(!empty));

endmodule

`default_nettype wire
